//--- design/mem_path_pkg.sv
`default_nettype none

package mem_path_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	// one select bit per byte lane
	localparam int SEL_W = DATA_W / 8;
	// top address bits cleared in kseg0 and kseg1
	localparam int KSEG_MASK_BITS = 3;

	////////////////////////////////////////
	// transaction types
	////////////////////////////////////////

	// which source a bus transaction belongs to
	typedef enum logic {
		SRC_INST = 1'b0,
		SRC_DATA = 1'b1
	} src_t;

	// cpu data command, virtual address
	typedef struct packed {
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [SEL_W-1:0]  sel;
	} data_cmd_t;

	// single-beat memory bus command, physical address
	typedef struct packed {
		logic              write;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] wdata;
		logic [SEL_W-1:0]  sel;
	} bus_cmd_t;

	// bus command tagged with its source
	typedef struct packed {
		bus_cmd_t cmd;
		src_t     src;
	} tagged_cmd_t;

	// read data routed back by source
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		src_t              src;
	} bus_resp_t;

endpackage

`default_nettype wire

//--- design/addr_map_stage.sv
`default_nettype none

module addr_map_stage #(
	parameter type payload_t = logic
) (
	input  wire logic                            clk,
	input  wire logic                            rst,
	// upstream
	input  wire logic                            in_valid_i,
	output logic                                 in_ready_o,
	input  wire logic [mem_path_pkg::ADDR_W-1:0] in_vaddr_i,
	input  wire payload_t                        in_payload_i,
	// downstream
	output logic                                 out_valid_o,
	input  wire logic                            out_ready_i,
	output logic [mem_path_pkg::ADDR_W-1:0]      out_paddr_o,
	output payload_t                             out_payload_o
);

	localparam int AW = mem_path_pkg::ADDR_W;
	localparam int KB = mem_path_pkg::KSEG_MASK_BITS;
	// segment codes of the two unmapped kernel windows
	localparam logic [KB-1:0] KSEG0 = KB'(3'b100);
	localparam logic [KB-1:0] KSEG1 = KB'(3'b101);

	logic [KB-1:0] seg;
	logic          unmapped;
	logic [AW-1:0] paddr;
	logic          valid_q;
	logic [AW-1:0] paddr_q;
	payload_t      payload_q;

	// kseg0/kseg1 drop the segment bits, kuseg and kseg2/3 pass as is
	assign seg      = in_vaddr_i[AW-1 -: KB];
	assign unmapped = (seg == KSEG0) || (seg == KSEG1);
	assign paddr    = unmapped ? {{KB{1'b0}}, in_vaddr_i[AW-KB-1:0]} : in_vaddr_i;

	// free slot, or the held item leaves this cycle
	assign in_ready_o = !valid_q || out_ready_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (in_ready_o) begin
			valid_q <= in_valid_i;
		end
	end

	// item register
	always_ff @(posedge clk) begin
		if (in_valid_i && in_ready_o) begin
			paddr_q   <= paddr;
			payload_q <= in_payload_i;
		end
	end

	assign out_valid_o   = valid_q;
	assign out_paddr_o   = paddr_q;
	assign out_payload_o = payload_q;

endmodule

`default_nettype wire

//--- design/fetch_ctrl.sv
`default_nettype none

module fetch_ctrl #(
	parameter logic [mem_path_pkg::ADDR_W-1:0] RESET_PC = 32'hBFC0_0000
) (
	input  wire logic                            clk,
	input  wire logic                            rst,
	// redirect from the cpu
	input  wire logic                            redirect_i,
	input  wire logic [mem_path_pkg::ADDR_W-1:0] redirect_pc_i,
	// fetch request toward the map stage
	output logic                                 req_valid_o,
	input  wire logic                            req_ready_i,
	output logic [mem_path_pkg::ADDR_W-1:0]      req_vaddr_o,
	// fetch response from the arbiter
	input  wire logic                            resp_valid_i,
	input  wire logic [mem_path_pkg::DATA_W-1:0] resp_rdata_i,
	// instruction out
	output logic                                 inst_valid_o,
	output logic [mem_path_pkg::DATA_W-1:0]      inst_o,
	output logic [mem_path_pkg::ADDR_W-1:0]      inst_addr_o
);

	localparam int AW = mem_path_pkg::ADDR_W;
	localparam int DW = mem_path_pkg::DATA_W;

	logic [AW-1:0] pc_q;
	logic          outstanding_q;
	// redirect seen since the outstanding fetch issued
	logic          discard_q;
	logic          issue;
	logic          resp;
	logic          inst_valid_q;
	logic [DW-1:0] inst_q;
	logic [AW-1:0] inst_addr_q;

	// one fetch in flight at most
	assign req_valid_o = !outstanding_q;
	assign req_vaddr_o = pc_q;
	assign issue       = req_valid_o && req_ready_i;
	assign resp        = resp_valid_i && outstanding_q;

	////////////////////////////////////////
	// pc and fetch tracking
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q          <= RESET_PC;
			outstanding_q <= 1'b0;
			discard_q     <= 1'b0;
			inst_valid_q  <= 1'b0;
		end else begin
			if (issue) begin
				outstanding_q <= 1'b1;
			end else if (resp) begin
				outstanding_q <= 1'b0;
			end
			// redirect in the issue cycle kills the fetch just sent
			if (issue) begin
				discard_q <= redirect_i;
			end else if (resp) begin
				discard_q <= 1'b0;
			end else if (redirect_i && outstanding_q) begin
				discard_q <= 1'b1;
			end
			// redirect wins over sequential advance
			if (redirect_i) begin
				pc_q <= redirect_pc_i;
			end else if (resp && !discard_q) begin
				pc_q <= pc_q + AW'(4);
			end
			inst_valid_q <= resp && !discard_q && !redirect_i;
		end
	end

	// fetched word and the pc it came from
	always_ff @(posedge clk) begin
		if (resp) begin
			inst_q      <= resp_rdata_i;
			inst_addr_q <= pc_q;
		end
	end

	assign inst_valid_o = inst_valid_q;
	assign inst_o       = inst_q;
	assign inst_addr_o  = inst_addr_q;

endmodule

`default_nettype wire

//--- design/data_port.sv
`default_nettype none

module data_port (
	input  wire logic                            clk,
	input  wire logic                            rst,
	// cpu side, four-phase
	input  wire logic                            data_req_i,
	input  wire mem_path_pkg::data_cmd_t         data_cmd_i,
	output logic                                 data_ack_o,
	output logic [mem_path_pkg::DATA_W-1:0]      data_rdata_o,
	// toward the map stage
	output logic                                 req_valid_o,
	input  wire logic                            req_ready_i,
	output logic [mem_path_pkg::ADDR_W-1:0]      req_vaddr_o,
	output mem_path_pkg::data_cmd_t              req_cmd_o,
	// response from the arbiter
	input  wire logic                            resp_valid_i,
	input  wire logic [mem_path_pkg::DATA_W-1:0] resp_rdata_i
);

	typedef enum logic [1:0] {
		D_IDLE,
		D_BUSY,
		D_ACKED
	} state_t;

	state_t                          state_q;
	logic [mem_path_pkg::DATA_W-1:0] rdata_q;

	// cpu holds the command until ack, so it feeds the pipe directly
	assign req_valid_o = (state_q == D_IDLE) && data_req_i;
	assign req_vaddr_o = data_cmd_i.addr;
	assign req_cmd_o   = data_cmd_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= D_IDLE;
		end else begin
			case (state_q)
				D_IDLE:  if (req_valid_o && req_ready_i) state_q <= D_BUSY;
				D_BUSY:  if (resp_valid_i) state_q <= D_ACKED;
				// ack stays up until the cpu drops req
				D_ACKED: if (!data_req_i) state_q <= D_IDLE;
				default: state_q <= D_IDLE;
			endcase
		end
	end

	// stores hand back zero
	always_ff @(posedge clk) begin
		if (state_q == D_BUSY && resp_valid_i) begin
			rdata_q <= data_cmd_i.write ? '0 : resp_rdata_i;
		end
	end

	assign data_ack_o   = (state_q == D_ACKED);
	assign data_rdata_o = rdata_q;

	// ack never drops while req is high
	a_ack_hold: assert property (@(posedge clk) disable iff (rst)
		$fell(data_ack_o) |-> !data_req_i);

endmodule

`default_nettype wire

//--- design/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
	input  wire logic                            clk,
	input  wire logic                            rst,
	// fetch side, already mapped
	input  wire logic                            inst_valid_i,
	output logic                                 inst_ready_o,
	input  wire logic [mem_path_pkg::ADDR_W-1:0] inst_paddr_i,
	// data side, already mapped
	input  wire logic                            data_valid_i,
	output logic                                 data_ready_o,
	input  wire logic [mem_path_pkg::ADDR_W-1:0] data_paddr_i,
	input  wire mem_path_pkg::data_cmd_t         data_cmd_i,
	// toward the bus master
	output logic                                 out_valid_o,
	input  wire logic                            out_ready_i,
	output mem_path_pkg::tagged_cmd_t            out_cmd_o,
	// response from the bus master
	input  wire logic                            resp_valid_i,
	input  wire mem_path_pkg::bus_resp_t         resp_i,
	// steered responses
	output logic                                 inst_resp_valid_o,
	output logic                                 data_resp_valid_o,
	output logic [mem_path_pkg::DATA_W-1:0]      resp_rdata_o
);

	logic                      can_accept;
	logic                      take;
	logic                      valid_q;
	mem_path_pkg::tagged_cmd_t next_cmd;
	mem_path_pkg::tagged_cmd_t cmd_q;

	////////////////////////////////////////
	// grant, data before fetch
	////////////////////////////////////////

	assign can_accept   = !valid_q || out_ready_i;
	assign data_ready_o = can_accept;
	assign inst_ready_o = can_accept && !data_valid_i;
	assign take         = can_accept && (data_valid_i || inst_valid_i);

	always_comb begin
		if (data_valid_i) begin
			next_cmd.cmd.write = data_cmd_i.write;
			next_cmd.cmd.paddr = data_paddr_i;
			next_cmd.cmd.wdata = data_cmd_i.wdata;
			next_cmd.cmd.sel   = data_cmd_i.sel;
			next_cmd.src       = mem_path_pkg::SRC_DATA;
		end else begin
			// fetch is a full-word read
			next_cmd.cmd.write = 1'b0;
			next_cmd.cmd.paddr = inst_paddr_i;
			next_cmd.cmd.wdata = '0;
			next_cmd.cmd.sel   = '1;
			next_cmd.src       = mem_path_pkg::SRC_INST;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (can_accept) begin
			valid_q <= data_valid_i || inst_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			cmd_q <= next_cmd;
		end
	end

	assign out_valid_o = valid_q;
	assign out_cmd_o   = cmd_q;

	// response goes back to whoever issued it
	assign inst_resp_valid_o = resp_valid_i && (resp_i.src == mem_path_pkg::SRC_INST);
	assign data_resp_valid_o = resp_valid_i && (resp_i.src == mem_path_pkg::SRC_DATA);
	assign resp_rdata_o      = resp_i.rdata;

endmodule

`default_nettype wire

//--- design/bus_master.sv
`default_nettype none

module bus_master (
	input  wire logic                            clk,
	input  wire logic                            rst,
	// from the arbiter
	input  wire logic                            in_valid_i,
	output logic                                 in_ready_o,
	input  wire mem_path_pkg::tagged_cmd_t       in_cmd_i,
	// memory side, four-phase
	output logic                                 mem_req_o,
	output mem_path_pkg::bus_cmd_t               mem_cmd_o,
	input  wire logic                            mem_ack_i,
	input  wire logic [mem_path_pkg::DATA_W-1:0] mem_rdata_i,
	// response back to the arbiter
	output logic                                 resp_valid_o,
	output mem_path_pkg::bus_resp_t              resp_o
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_REQ,
		M_RELEASE,
		M_WAIT_LOW
	} state_t;

	state_t                          state_q;
	mem_path_pkg::tagged_cmd_t       cmd_q;
	logic [mem_path_pkg::DATA_W-1:0] rdata_q;

	// new item only once the previous handshake is fully closed
	assign in_ready_o = (state_q == M_IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= M_IDLE;
		end else begin
			case (state_q)
				M_IDLE:     if (in_valid_i) state_q <= M_REQ;
				M_REQ:      if (mem_ack_i) state_q <= M_RELEASE;
				// req already low here, wait for memory to drop ack
				M_RELEASE:  state_q <= mem_ack_i ? M_WAIT_LOW : M_IDLE;
				M_WAIT_LOW: if (!mem_ack_i) state_q <= M_IDLE;
				default:    state_q <= M_IDLE;
			endcase
		end
	end

	// command and tag held for the whole transaction
	always_ff @(posedge clk) begin
		if (in_valid_i && in_ready_o) begin
			cmd_q <= in_cmd_i;
		end
		if (state_q == M_REQ && mem_ack_i) begin
			rdata_q <= mem_rdata_i;
		end
	end

	assign mem_req_o    = (state_q == M_REQ);
	assign mem_cmd_o    = cmd_q.cmd;
	// single pulse right after the first ack
	assign resp_valid_o = (state_q == M_RELEASE);
	assign resp_o       = mem_path_pkg::bus_resp_t'{rdata: rdata_q, src: cmd_q.src};

	a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req_o |=> !mem_req_o || $stable(mem_cmd_o));
	a_no_req_on_ack: assert property (@(posedge clk) disable iff (rst)
		$rose(mem_req_o) |-> !mem_ack_i);

endmodule

`default_nettype wire

//--- design/uncached_access_top.sv
`default_nettype none

module uncached_access_top #(
	parameter logic [mem_path_pkg::ADDR_W-1:0] RESET_PC = 32'hBFC0_0000
) (
	input  wire logic                            clk,
	input  wire logic                            rst,
	// fetch side
	input  wire logic                            redirect_i,
	input  wire logic [mem_path_pkg::ADDR_W-1:0] redirect_pc_i,
	output logic                                 inst_valid_o,
	output logic [mem_path_pkg::DATA_W-1:0]      inst_o,
	output logic [mem_path_pkg::ADDR_W-1:0]      inst_addr_o,
	// data side
	input  wire logic                            data_req_i,
	input  wire mem_path_pkg::data_cmd_t         data_cmd_i,
	output logic                                 data_ack_o,
	output logic [mem_path_pkg::DATA_W-1:0]      data_rdata_o,
	// memory side
	output logic                                 mem_req_o,
	output mem_path_pkg::bus_cmd_t               mem_cmd_o,
	input  wire logic                            mem_ack_i,
	input  wire logic [mem_path_pkg::DATA_W-1:0] mem_rdata_i
);

	localparam int AW = mem_path_pkg::ADDR_W;
	localparam int DW = mem_path_pkg::DATA_W;

	////////////////////////////////////////
	// sources
	////////////////////////////////////////

	logic                    if_valid, if_ready;
	logic [AW-1:0]           if_vaddr;
	logic                    dp_valid, dp_ready;
	logic [AW-1:0]           dp_vaddr;
	mem_path_pkg::data_cmd_t dp_cmd;
	logic                    inst_resp_valid, data_resp_valid;
	logic [DW-1:0]           resp_rdata;

	fetch_ctrl #(.RESET_PC(RESET_PC)) i_fetch (
		.clk, .rst, .redirect_i, .redirect_pc_i,
		.req_valid_o(if_valid), .req_ready_i(if_ready), .req_vaddr_o(if_vaddr),
		.resp_valid_i(inst_resp_valid), .resp_rdata_i(resp_rdata),
		.inst_valid_o, .inst_o, .inst_addr_o
	);

	data_port i_data_port (
		.clk, .rst, .data_req_i, .data_cmd_i, .data_ack_o, .data_rdata_o,
		.req_valid_o(dp_valid), .req_ready_i(dp_ready), .req_vaddr_o(dp_vaddr),
		.req_cmd_o(dp_cmd), .resp_valid_i(data_resp_valid), .resp_rdata_i(resp_rdata)
	);

	////////////////////////////////////////
	// mapping, arbitration, bus
	////////////////////////////////////////

	logic                      im_valid, im_ready;
	logic [AW-1:0]             im_paddr;
	logic                      dm_valid, dm_ready;
	logic [AW-1:0]             dm_paddr;
	mem_path_pkg::data_cmd_t   dm_cmd;
	logic                      arb_valid, arb_ready;
	mem_path_pkg::tagged_cmd_t arb_cmd;
	logic                      bus_resp_valid;
	mem_path_pkg::bus_resp_t   bus_resp;

	// fetch tag is implied by the arbiter inst port
	addr_map_stage #(.payload_t(mem_path_pkg::src_t)) inst_map (
		.clk, .rst,
		.in_valid_i(if_valid), .in_ready_o(if_ready), .in_vaddr_i(if_vaddr),
		.in_payload_i(mem_path_pkg::SRC_INST),
		.out_valid_o(im_valid), .out_ready_i(im_ready), .out_paddr_o(im_paddr),
		.out_payload_o()
	);

	addr_map_stage #(.payload_t(mem_path_pkg::data_cmd_t)) data_map (
		.clk, .rst,
		.in_valid_i(dp_valid), .in_ready_o(dp_ready), .in_vaddr_i(dp_vaddr),
		.in_payload_i(dp_cmd),
		.out_valid_o(dm_valid), .out_ready_i(dm_ready), .out_paddr_o(dm_paddr),
		.out_payload_o(dm_cmd)
	);

	bus_arbiter i_arbiter (
		.clk, .rst,
		.inst_valid_i(im_valid), .inst_ready_o(im_ready), .inst_paddr_i(im_paddr),
		.data_valid_i(dm_valid), .data_ready_o(dm_ready), .data_paddr_i(dm_paddr),
		.data_cmd_i(dm_cmd),
		.out_valid_o(arb_valid), .out_ready_i(arb_ready), .out_cmd_o(arb_cmd),
		.resp_valid_i(bus_resp_valid), .resp_i(bus_resp),
		.inst_resp_valid_o(inst_resp_valid), .data_resp_valid_o(data_resp_valid),
		.resp_rdata_o(resp_rdata)
	);

	bus_master i_master (
		.clk, .rst,
		.in_valid_i(arb_valid), .in_ready_o(arb_ready), .in_cmd_i(arb_cmd),
		.mem_req_o, .mem_cmd_o, .mem_ack_i, .mem_rdata_i,
		.resp_valid_o(bus_resp_valid), .resp_o(bus_resp)
	);

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
`default_nettype none

module tb_checker #(
	parameter logic [31:0] RESET_PC = 32'hBFC0_0000
) (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    redirect_i,
	input  wire logic [31:0]             redirect_pc_i,
	input  wire logic                    inst_valid_i,
	input  wire logic [31:0]             inst_i,
	input  wire logic [31:0]             inst_addr_i,
	input  wire logic                    data_req_i,
	input  wire mem_path_pkg::data_cmd_t data_cmd_i,
	input  wire logic                    data_ack_i,
	input  wire logic [31:0]             data_rdata_i,
	input  wire logic                    mem_req_i,
	input  wire mem_path_pkg::bus_cmd_t  mem_cmd_i,
	input  wire logic                    mem_ack_i,
	input  wire logic                    done_i,
	input  wire logic [31:0]             timeouts_i,
	output int                           err_count_o
);

	localparam logic [31:0] INST_XOR  = 32'h5A5A_C3C3;
	// longest stretch without an instruction
	localparam int          GAP_LIMIT = 300;

	logic [31:0]             model_mem [logic [29:0]];
	logic [31:0]             exp_pc = RESET_PC;
	logic                    started = 1'b0;
	logic                    first_req_seen = 1'b0;
	logic                    reported = 1'b0;
	logic                    prev_data_req = 1'b0;
	logic                    prev_data_ack = 1'b0;
	logic                    prev_mem_req = 1'b0;
	logic                    prev_mem_ack = 1'b0;
	mem_path_pkg::bus_cmd_t  prev_mem_cmd = '0;
	mem_path_pkg::data_cmd_t cur_data = '0;
	logic                    data_open = 1'b0;
	logic                    data_matched = 1'b0;
	int                      errors = 0;
	int                      inst_count = 0;
	int                      data_count = 0;
	int                      gap = 0;

	assign err_count_o = errors;

	// segment rule: kseg0/kseg1 lose their top three bits
	function automatic logic [31:0] map_addr(input logic [31:0] va);
		if (va[31:29] == 3'b100 || va[31:29] == 3'b101) begin
			return {3'b000, va[28:0]};
		end
		return va;
	endfunction

	function automatic logic [31:0] model_word(input logic [31:0] pa);
		if (model_mem.exists(pa[31:2])) begin
			return model_mem[pa[31:2]];
		end
		return ~pa ^ 32'h1357_9BDF;
	endfunction

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
		errors++;
	endtask

	task automatic fault(input string what);
		$display("t=%0t %s", $time, what);
		errors++;
	endtask

	always @(posedge clk) begin
		logic [31:0] word;
		logic [31:0] pa;
		if (rst) begin
			exp_pc  = RESET_PC;
			started = 1'b0;
		end else begin
			if (!started) begin
				started = 1'b1;
				if (mem_req_i || data_ack_i || inst_valid_i) begin
					fault("outputs were not idle after reset");
				end
			end

			////////////////////////////////////////
			// fetch stream
			////////////////////////////////////////
			if (inst_valid_i) begin
				if (inst_addr_i != exp_pc) begin
					mismatch("inst_addr_o", inst_addr_i, exp_pc);
				end
				if (inst_i != (map_addr(inst_addr_i) ^ INST_XOR)) begin
					mismatch("inst_o", inst_i, map_addr(inst_addr_i) ^ INST_XOR);
				end
				exp_pc = inst_addr_i + 32'd4;
				inst_count++;
				gap = 0;
			end else begin
				gap++;
				if (gap == GAP_LIMIT) begin
					fault("fetch delivered no instruction for too long");
				end
			end
			// redirect here only affects later instructions
			if (redirect_i) begin
				exp_pc = redirect_pc_i;
			end

			////////////////////////////////////////
			// data port
			////////////////////////////////////////
			if (data_req_i && !prev_data_req) begin
				cur_data     = data_cmd_i;
				data_open    = 1'b1;
				data_matched = 1'b0;
			end
			if (data_ack_i && !prev_data_ack) begin
				if (!data_req_i) begin
					fault("data_ack_o rose without data_req_i");
				end
				if (!data_matched) begin
					fault("data ack came without a matching memory request");
				end
				pa   = map_addr(cur_data.addr);
				word = model_word(pa);
				if (cur_data.write) begin
					if (data_rdata_i != 32'h0) begin
						mismatch("data_rdata_o", data_rdata_i, 32'h0);
					end
					for (int b = 0; b < 4; b++) begin
						if (cur_data.sel[b]) begin
							word[8*b +: 8] = cur_data.wdata[8*b +: 8];
						end
					end
					model_mem[pa[31:2]] = word;
				end else if (data_rdata_i != word) begin
					mismatch("data_rdata_o", data_rdata_i, word);
				end
				data_open = 1'b0;
				data_count++;
			end
			if (!data_ack_i && prev_data_ack && prev_data_req) begin
				fault("data_ack_o fell while data_req_i was still high");
			end

			////////////////////////////////////////
			// memory port
			////////////////////////////////////////
			if (mem_req_i && !prev_mem_req) begin
				if (mem_ack_i) begin
					fault("mem_req_o rose while mem_ack_i was high");
				end
				if (!first_req_seen) begin
					first_req_seen = 1'b1;
					if (mem_cmd_i.paddr != map_addr(RESET_PC)) begin
						mismatch("mem_cmd_o.paddr", mem_cmd_i.paddr, map_addr(RESET_PC));
					end
				end
				// data window is disjoint from the fetch region
				if (data_open && !data_matched && mem_cmd_i.paddr[31:12] == 20'h00001) begin
					data_matched = 1'b1;
					if (mem_cmd_i.paddr != map_addr(cur_data.addr)) begin
						mismatch("mem_cmd_o.paddr", mem_cmd_i.paddr, map_addr(cur_data.addr));
					end
					if (mem_cmd_i.write != cur_data.write) begin
						fault("memory write flag differs from the data request");
					end else if (cur_data.write) begin
						if (mem_cmd_i.wdata != cur_data.wdata) begin
							mismatch("mem_cmd_o.wdata", mem_cmd_i.wdata, cur_data.wdata);
						end
						if (mem_cmd_i.sel != cur_data.sel) begin
							mismatch("mem_cmd_o.sel", {28'd0, mem_cmd_i.sel}, {28'd0, cur_data.sel});
						end
					end
				end else begin
					if (mem_cmd_i.write) begin
						fault("fetch request went out as a write");
					end
					if (mem_cmd_i.sel != 4'hF) begin
						mismatch("mem_cmd_o.sel", {28'd0, mem_cmd_i.sel}, 32'hF);
					end
					if (mem_cmd_i.paddr[31:20] != 12'h1FC) begin
						fault("fetch address left the fetch region");
					end
				end
			end
			if (!mem_req_i && prev_mem_req && !prev_mem_ack) begin
				fault("mem_req_o fell before mem_ack_i");
			end
			if (mem_req_i && prev_mem_req && mem_cmd_i != prev_mem_cmd) begin
				fault("mem_cmd_o changed while mem_req_o was high");
			end

			if (done_i && !reported) begin
				reported = 1'b1;
				$display("errors %0d, timeouts %0d, instructions %0d, data transactions %0d",
					errors, timeouts_i, inst_count, data_count);
			end
		end
		prev_data_req = data_req_i;
		prev_data_ack = data_ack_i;
		prev_mem_req  = mem_req_i;
		prev_mem_ack  = mem_ack_i;
		prev_mem_cmd  = mem_cmd_i;
	end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
`default_nettype none

module tb_top;

	localparam logic [31:0] RESET_PC    = 32'hBFC0_0000;
	localparam int          N_DATA      = 300;
	localparam int          ACK_TIMEOUT = 500;
	// fetch region returns address xor this
	localparam logic [31:0] INST_XOR    = 32'h5A5A_C3C3;

	logic                    clk = 1'b0;
	logic                    rst = 1'b1;
	logic                    redirect_i = 1'b0;
	logic [31:0]             redirect_pc_i = 32'h0;
	logic                    inst_valid_o;
	logic [31:0]             inst_o;
	logic [31:0]             inst_addr_o;
	logic                    data_req_i = 1'b0;
	mem_path_pkg::data_cmd_t data_cmd_i = '0;
	logic                    data_ack_o;
	logic [31:0]             data_rdata_o;
	logic                    mem_req_o;
	mem_path_pkg::bus_cmd_t  mem_cmd_o;
	logic                    mem_ack_i = 1'b0;
	logic [31:0]             mem_rdata_i = 32'h0;

	logic                    done = 1'b0;
	int                      timeouts = 0;
	int                      err_count;

	uncached_access_top #(.RESET_PC(RESET_PC)) i_dut (
		.clk, .rst, .redirect_i, .redirect_pc_i, .inst_valid_o, .inst_o, .inst_addr_o,
		.data_req_i, .data_cmd_i, .data_ack_o, .data_rdata_o,
		.mem_req_o, .mem_cmd_o, .mem_ack_i, .mem_rdata_i
	);

	tb_checker #(.RESET_PC(RESET_PC)) i_checker (
		.clk, .rst, .redirect_i, .redirect_pc_i,
		.inst_valid_i(inst_valid_o), .inst_i(inst_o), .inst_addr_i(inst_addr_o),
		.data_req_i, .data_cmd_i, .data_ack_i(data_ack_o), .data_rdata_i(data_rdata_o),
		.mem_req_i(mem_req_o), .mem_cmd_i(mem_cmd_o), .mem_ack_i,
		.done_i(done), .timeouts_i(timeouts), .err_count_o(err_count)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////
	// memory responder
	////////////////////////////////////////

	// sparse data window, keyed by word address
	logic [31:0] data_mem [logic [29:0]];
	int unsigned ack_delay = 0;

	function automatic logic [31:0] read_word(input logic [31:0] paddr);
		if (paddr[31:12] == 20'h00001) begin
			if (data_mem.exists(paddr[31:2])) begin
				return data_mem[paddr[31:2]];
			end
			// untouched words, pattern over the whole address
			return ~paddr ^ 32'h1357_9BDF;
		end
		return paddr ^ INST_XOR;
	endfunction

	always @(posedge clk) begin
		logic [31:0] word;
		if (rst) begin
			mem_ack_i <= 1'b0;
		end else if (mem_ack_i) begin
			// drop ack once the master releases req
			if (!mem_req_o) begin
				mem_ack_i <= 1'b0;
			end
		end else if (mem_req_o) begin
			if (ack_delay == 0) begin
				word = read_word(mem_cmd_o.paddr);
				if (mem_cmd_o.write) begin
					for (int b = 0; b < 4; b++) begin
						if (mem_cmd_o.sel[b]) begin
							word[8*b +: 8] = mem_cmd_o.wdata[8*b +: 8];
						end
					end
					data_mem[mem_cmd_o.paddr[31:2]] = word;
				end
				// stores echo the merged word back on the bus
				mem_rdata_i <= word;
				mem_ack_i <= 1'b1;
				ack_delay <= $urandom_range(5, 0);
			end else begin
				ack_delay <= ack_delay - 1;
			end
		end
	end

	// random redirects into the fetch region, about 1 in 20 cycles
	always @(posedge clk) begin
		if (rst) begin
			redirect_i <= 1'b0;
		end else begin
			redirect_i    <= ($urandom_range(19, 0) == 0);
			redirect_pc_i <= RESET_PC + {22'd0, 8'($urandom_range(255, 0)), 2'b00};
		end
	end

	////////////////////////////////////////
	// cpu data driver
	////////////////////////////////////////

	// kuseg, kseg0 and kseg1 views of one physical window
	function automatic logic [31:0] seg_base(input int unsigned seg);
		case (seg)
			0:       return 32'h0000_1000;
			1:       return 32'h8000_1000;
			default: return 32'hA000_1000;
		endcase
	endfunction

	task automatic run_data_txn();
		mem_path_pkg::data_cmd_t cmd;
		int unsigned             seg;
		int                      wait_cnt;
		seg       = $urandom_range(2, 0);
		cmd.write = 1'($urandom_range(1, 0));
		cmd.addr  = seg_base(seg) + {27'd0, 3'($urandom_range(7, 0)), 2'b00};
		cmd.wdata = $urandom();
		cmd.sel   = 4'($urandom_range(15, 1));
		data_req_i <= 1'b1;
		data_cmd_i <= cmd;
		wait_cnt = 0;
		@(posedge clk);
		while (!data_ack_o && wait_cnt < ACK_TIMEOUT) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (!data_ack_o) begin
			$display("t=%0t data request at %h was never acknowledged", $time, cmd.addr);
			timeouts++;
		end
		data_req_i <= 1'b0;
		wait_cnt = 0;
		@(posedge clk);
		while (data_ack_o && wait_cnt < ACK_TIMEOUT) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (data_ack_o) begin
			$display("t=%0t data ack stayed high after the request was dropped", $time);
			timeouts++;
		end
	endtask

	initial begin
		void'($urandom(32'h6261_bd2c));
		rst = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		// let the first fetch reach the bus before data starts
		repeat (5) @(posedge clk);
		for (int i = 0; i < N_DATA; i++) begin
			run_data_txn();
			repeat ($urandom_range(3, 0)) @(posedge clk);
		end
		repeat (50) @(posedge clk);
		done <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		if (err_count == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// hard stop for a hung run
	initial begin
		#1_000_000;
		$display("simulation ran past its time limit");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
design/mem_path_pkg.sv
design/addr_map_stage.sv
design/fetch_ctrl.sv
design/data_port.sv
design/bus_arbiter.sv
design/bus_master.sv
design/uncached_access_top.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the uncached access path testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_top -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
